//--- hdl/tcm_pkg.sv
/*
 * Address map, widths and shared types for the ITCM/DTCM subsystem.
 * Every RTL file refers to these by scoped names.
 */
package tcm_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;
    typedef logic [7:0]  word_idx_t;
    typedef logic [2:0]  cnt_t;
    typedef logic [1:0]  fifo_ptr_t;

    localparam addr_t       ITCM_BASE        = 32'h8000_0000;
    localparam addr_t       DTCM_BASE        = 32'h8010_0000;
    localparam int unsigned TCM_SIZE         = 1024;
    localparam int unsigned TCM_WORDS        = 256;
    localparam int unsigned MAX_OUTSTANDING  = 4;
    localparam int unsigned FETCH_FIFO_DEPTH = 4;

    // owner of a pending ITCM read
    typedef enum logic {OWNER_M0, OWNER_M1} rd_owner_e;
    // M1 target on one channel
    typedef enum logic {TGT_ITCM, TGT_DTCM} target_e;

    function automatic logic in_itcm(addr_t addr);
        return (addr >= ITCM_BASE) && (addr < ITCM_BASE + TCM_SIZE);
    endfunction

    function automatic logic in_dtcm(addr_t addr);
        return (addr >= DTCM_BASE) && (addr < DTCM_BASE + TCM_SIZE);
    endfunction

endpackage

//--- hdl/tcm_if.sv
/*
 * Single-beat AXI-lite style read and write channels between the
 * router, the ITCM arbiter and the two memories.
 */
`timescale 1ns/10ps

interface tcm_rd_if;
    tcm_pkg::addr_t araddr;
    logic           arvalid;
    logic           arready;
    tcm_pkg::data_t rdata;
    logic           rvalid;
    logic           rready;

    modport master (output araddr, arvalid, rready, input arready, rdata, rvalid);
    modport slave (input araddr, arvalid, rready, output arready, rdata, rvalid);
endinterface

interface tcm_wr_if;
    tcm_pkg::addr_t awaddr;
    logic           awvalid;
    logic           awready;
    tcm_pkg::data_t wdata;
    tcm_pkg::strb_t wstrb;
    logic           wvalid;
    logic           wready;
    logic           bvalid;
    logic           bready;

    modport master (
        output awaddr, awvalid, wdata, wstrb, wvalid, bready,
        input  awready, wready, bvalid
    );
    modport slave (
        input  awaddr, awvalid, wdata, wstrb, wvalid, bready,
        output awready, wready, bvalid
    );
endinterface

//--- hdl/tcm_ram.sv
/*
 * One TCM bank of 256 words. Reads return after one cycle through a
 * single output register; writes merge bytes under the strobes and
 * answer on bvalid the cycle after.
 */
`timescale 1ns/10ps

module tcm_ram (
    input logic          clk,
    input logic          rst_n,
    tcm_rd_if.slave      rd,
    tcm_wr_if.slave      wr
);

    tcm_pkg::data_t mem [tcm_pkg::TCM_WORDS];

    tcm_pkg::word_idx_t rd_idx;
    tcm_pkg::word_idx_t wr_idx;
    logic               rd_go;
    logic               wr_go;

    // word index from byte address bits 9:2
    assign rd_idx = rd.araddr[9:2];
    assign wr_idx = wr.awaddr[9:2];

    // the output register frees up when its word is taken
    assign rd.arready = !rd.rvalid || rd.rready;
    assign rd_go      = rd.arvalid && rd.arready;

    // address and data are taken together, one beat per write
    assign wr_go      = wr.awvalid && wr.wvalid && (!wr.bvalid || wr.bready);
    assign wr.awready = wr_go;
    assign wr.wready  = wr_go;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd.rvalid <= 1'b0;
            wr.bvalid <= 1'b0;
        end else begin
            if (rd_go) begin
                rd.rvalid <= 1'b1;
            end else if (rd.rready) begin
                rd.rvalid <= 1'b0;
            end
            if (wr_go) begin
                wr.bvalid <= 1'b1;
            end else if (wr.bready) begin
                wr.bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_go) begin
            rd.rdata <= mem[rd_idx];
        end
        if (wr_go) begin
            for (int b = 0; b < 4; b++) begin
                if (wr.wstrb[b]) begin
                    mem[wr_idx][8*b +: 8] <= wr.wdata[8*b +: 8];
                end
            end
        end
    end

    // a stalled read word must not change under the master
    rdata_hold_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        rd.rvalid && !rd.rready |=> $stable(rd.rdata)
    );

endmodule

//--- hdl/fetch_resp_fifo.sv
/*
 * Four-entry buffer for ITCM words owed to the fetch port.
 * A push shows at the output on the next cycle.
 */
`timescale 1ns/10ps

module fetch_resp_fifo (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           push,
    input  tcm_pkg::data_t push_data,
    input  logic           pop,
    output logic           out_valid,
    output tcm_pkg::data_t out_data,
    output logic           full
);

    tcm_pkg::data_t     buf_mem [tcm_pkg::FETCH_FIFO_DEPTH];
    tcm_pkg::fifo_ptr_t wr_ptr;
    tcm_pkg::fifo_ptr_t rd_ptr;
    tcm_pkg::cnt_t      count;

    assign out_valid = (count != '0);
    assign full      = (count == tcm_pkg::cnt_t'(tcm_pkg::FETCH_FIFO_DEPTH));
    assign out_data  = buf_mem[rd_ptr];

    // pointers wrap on their own at depth 4
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + tcm_pkg::cnt_t'(push) - tcm_pkg::cnt_t'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            buf_mem[wr_ptr] <= push_data;
        end
    end

    // the arbiter's credit count must keep these from happening
    no_overflow_a: assert property (
        @(posedge clk) disable iff (!rst_n) push |-> !full
    );
    no_underflow_a: assert property (
        @(posedge clk) disable iff (!rst_n) pop |-> out_valid
    );

endmodule

//--- hdl/itcm_read_arbiter.sv
/*
 * Shares the ITCM read channel between the fetch port and the data
 * router. M1 has fixed priority; M0 words always land in the fetch
 * buffer so a stalled fetch never holds up M1.
 */
`timescale 1ns/10ps

module itcm_read_arbiter (
    input  logic           clk,
    input  logic           rst_n,
    input  tcm_pkg::addr_t m0_araddr,
    input  logic           m0_arvalid,
    output logic           m0_arready,
    output tcm_pkg::data_t m0_rdata,
    output logic           m0_rvalid,
    input  logic           m0_rready,
    tcm_rd_if.slave        m1,
    tcm_rd_if.master       itcm
);

    tcm_pkg::cnt_t        m0_credit;
    tcm_pkg::rd_owner_e   rsp_owner;
    logic                 m0_has_credit;
    logic                 m0_grant;
    logic                 fifo_push;
    logic                 fifo_pop;
    logic                 fifo_full;

    // in-flight plus buffered fetches may not exceed the buffer depth
    assign m0_has_credit = m0_credit < tcm_pkg::cnt_t'(tcm_pkg::FETCH_FIFO_DEPTH);
    assign m0_grant      = m0_arvalid && !m1.arvalid && m0_has_credit;

    assign itcm.araddr  = m1.arvalid ? m1.araddr : m0_araddr;
    assign itcm.arvalid = m1.arvalid || m0_grant;
    assign m1.arready   = itcm.arready;
    assign m0_arready   = m0_grant && itcm.arready;

    // the ram holds one word at a time, so the owner queue is one entry deep
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_owner <= tcm_pkg::OWNER_M0;
            m0_credit <= '0;
        end else begin
            if (itcm.arvalid && itcm.arready) begin
                rsp_owner <= m1.arvalid ? tcm_pkg::OWNER_M1 : tcm_pkg::OWNER_M0;
            end
            m0_credit <= m0_credit + tcm_pkg::cnt_t'(m0_arvalid && m0_arready)
                                   - tcm_pkg::cnt_t'(fifo_pop);
        end
    end

    // response routing by owner
    assign fifo_push   = itcm.rvalid && (rsp_owner == tcm_pkg::OWNER_M0);
    assign itcm.rready = (rsp_owner == tcm_pkg::OWNER_M0) ? !fifo_full : m1.rready;
    assign m1.rvalid   = itcm.rvalid && (rsp_owner == tcm_pkg::OWNER_M1);
    assign m1.rdata    = itcm.rdata;
    assign fifo_pop    = m0_rvalid && m0_rready;

    fetch_resp_fifo i_fetch_resp_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (fifo_push),
        .push_data (itcm.rdata),
        .pop       (fifo_pop),
        .out_valid (m0_rvalid),
        .out_data  (m0_rdata),
        .full      (fifo_full)
    );

    m0_in_itcm_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        m0_arvalid && m0_arready |-> tcm_pkg::in_itcm(m0_araddr)
    );

endmodule

//--- hdl/data_port_router.sv
/*
 * Steers data-port reads and writes to the ITCM or the DTCM.
 * Outstanding transactions are counted per target; a channel only
 * moves to the other target once the current one has drained.
 */
`timescale 1ns/10ps

module data_port_router (
    input  logic           clk,
    input  logic           rst_n,
    input  tcm_pkg::addr_t m1_araddr,
    input  logic           m1_arvalid,
    output logic           m1_arready,
    output tcm_pkg::data_t m1_rdata,
    output logic           m1_rvalid,
    input  logic           m1_rready,
    input  tcm_pkg::addr_t m1_awaddr,
    input  logic           m1_awvalid,
    output logic           m1_awready,
    input  tcm_pkg::data_t m1_wdata,
    input  tcm_pkg::strb_t m1_wstrb,
    input  logic           m1_wvalid,
    output logic           m1_wready,
    output logic           m1_bvalid,
    input  logic           m1_bready,
    tcm_rd_if.master       itcm_rd,
    tcm_rd_if.master       dtcm_rd,
    tcm_wr_if.master       itcm_wr,
    tcm_wr_if.master       dtcm_wr
);

    localparam tcm_pkg::cnt_t CNT_MAX = tcm_pkg::cnt_t'(tcm_pkg::MAX_OUTSTANDING);

    tcm_pkg::cnt_t   rd_cnt [2];
    tcm_pkg::cnt_t   wr_cnt [2];
    tcm_pkg::target_e rd_tgt;
    tcm_pkg::target_e wr_tgt;
    tcm_pkg::target_e ar_tgt;
    tcm_pkg::target_e aw_tgt;
    logic            ar_ok;
    logic            aw_ok;
    logic [1:0]      ar_inc;
    logic [1:0]      r_dec;
    logic [1:0]      aw_inc;
    logic [1:0]      b_dec;

    // anything outside the ITCM window is taken as DTCM
    assign ar_tgt = tcm_pkg::in_itcm(m1_araddr) ? tcm_pkg::TGT_ITCM : tcm_pkg::TGT_DTCM;
    assign aw_tgt = tcm_pkg::in_itcm(m1_awaddr) ? tcm_pkg::TGT_ITCM : tcm_pkg::TGT_DTCM;

    // same target, or the old one drained, and room left on the new one
    assign ar_ok = ((ar_tgt == rd_tgt) || (rd_cnt[rd_tgt] == '0)) && (rd_cnt[ar_tgt] < CNT_MAX);
    assign aw_ok = ((aw_tgt == wr_tgt) || (wr_cnt[wr_tgt] == '0)) && (wr_cnt[aw_tgt] < CNT_MAX);

    // read address and data
    assign itcm_rd.araddr  = m1_araddr;
    assign dtcm_rd.araddr  = m1_araddr;
    assign itcm_rd.arvalid = m1_arvalid && ar_ok && (ar_tgt == tcm_pkg::TGT_ITCM);
    assign dtcm_rd.arvalid = m1_arvalid && ar_ok && (ar_tgt == tcm_pkg::TGT_DTCM);
    assign m1_arready = ar_ok && ((ar_tgt == tcm_pkg::TGT_ITCM) ? itcm_rd.arready : dtcm_rd.arready);
    assign itcm_rd.rready = m1_rready && (rd_tgt == tcm_pkg::TGT_ITCM);
    assign dtcm_rd.rready = m1_rready && (rd_tgt == tcm_pkg::TGT_DTCM);
    assign m1_rvalid = (rd_tgt == tcm_pkg::TGT_ITCM) ? itcm_rd.rvalid : dtcm_rd.rvalid;
    assign m1_rdata  = (rd_tgt == tcm_pkg::TGT_ITCM) ? itcm_rd.rdata : dtcm_rd.rdata;

    // write address, data and response
    assign itcm_wr.awaddr  = m1_awaddr;
    assign dtcm_wr.awaddr  = m1_awaddr;
    assign itcm_wr.wdata   = m1_wdata;
    assign dtcm_wr.wdata   = m1_wdata;
    assign itcm_wr.wstrb   = m1_wstrb;
    assign dtcm_wr.wstrb   = m1_wstrb;
    assign itcm_wr.awvalid = m1_awvalid && aw_ok && (aw_tgt == tcm_pkg::TGT_ITCM);
    assign dtcm_wr.awvalid = m1_awvalid && aw_ok && (aw_tgt == tcm_pkg::TGT_DTCM);
    assign itcm_wr.wvalid  = m1_wvalid && aw_ok && (aw_tgt == tcm_pkg::TGT_ITCM);
    assign dtcm_wr.wvalid  = m1_wvalid && aw_ok && (aw_tgt == tcm_pkg::TGT_DTCM);
    assign m1_awready = aw_ok && ((aw_tgt == tcm_pkg::TGT_ITCM) ? itcm_wr.awready : dtcm_wr.awready);
    assign m1_wready  = aw_ok && ((aw_tgt == tcm_pkg::TGT_ITCM) ? itcm_wr.wready : dtcm_wr.wready);
    assign itcm_wr.bready = m1_bready && (wr_tgt == tcm_pkg::TGT_ITCM);
    assign dtcm_wr.bready = m1_bready && (wr_tgt == tcm_pkg::TGT_DTCM);
    assign m1_bvalid = (wr_tgt == tcm_pkg::TGT_ITCM) ? itcm_wr.bvalid : dtcm_wr.bvalid;

    // handshakes per target, indexed by target_e
    assign ar_inc = {dtcm_rd.arvalid && dtcm_rd.arready, itcm_rd.arvalid && itcm_rd.arready};
    assign r_dec  = {dtcm_rd.rvalid && dtcm_rd.rready, itcm_rd.rvalid && itcm_rd.rready};
    assign aw_inc = {dtcm_wr.awvalid && dtcm_wr.awready, itcm_wr.awvalid && itcm_wr.awready};
    assign b_dec  = {dtcm_wr.bvalid && dtcm_wr.bready, itcm_wr.bvalid && itcm_wr.bready};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int t = 0; t < 2; t++) begin
                rd_cnt[t] <= '0;
                wr_cnt[t] <= '0;
            end
            rd_tgt <= tcm_pkg::TGT_ITCM;
            wr_tgt <= tcm_pkg::TGT_ITCM;
        end else begin
            for (int t = 0; t < 2; t++) begin
                rd_cnt[t] <= rd_cnt[t] + tcm_pkg::cnt_t'(ar_inc[t]) - tcm_pkg::cnt_t'(r_dec[t]);
                wr_cnt[t] <= wr_cnt[t] + tcm_pkg::cnt_t'(aw_inc[t]) - tcm_pkg::cnt_t'(b_dec[t]);
            end
            if (m1_arvalid && m1_arready) begin
                rd_tgt <= ar_tgt;
            end
            if (m1_awvalid && m1_awready) begin
                wr_tgt <= aw_tgt;
            end
        end
    end

    ar_in_window_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        m1_arvalid && m1_arready |-> tcm_pkg::in_itcm(m1_araddr) || tcm_pkg::in_dtcm(m1_araddr)
    );
    aw_in_window_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        m1_awvalid && m1_awready |-> tcm_pkg::in_itcm(m1_awaddr) || tcm_pkg::in_dtcm(m1_awaddr)
    );

endmodule

//--- hdl/tcm_subsystem.sv
/*
 * Top level of the TCM subsystem: fetch port M0 (ITCM reads only) and
 * data port M1 (reads and writes to both banks).
 */
`timescale 1ns/10ps

module tcm_subsystem (
    input  logic           clk,
    input  logic           rst_n,
    input  tcm_pkg::addr_t m0_araddr,
    input  logic           m0_arvalid,
    output logic           m0_arready,
    output tcm_pkg::data_t m0_rdata,
    output logic           m0_rvalid,
    input  logic           m0_rready,
    input  tcm_pkg::addr_t m1_araddr,
    input  logic           m1_arvalid,
    output logic           m1_arready,
    output tcm_pkg::data_t m1_rdata,
    output logic           m1_rvalid,
    input  logic           m1_rready,
    input  tcm_pkg::addr_t m1_awaddr,
    input  logic           m1_awvalid,
    output logic           m1_awready,
    input  tcm_pkg::data_t m1_wdata,
    input  tcm_pkg::strb_t m1_wstrb,
    input  logic           m1_wvalid,
    output logic           m1_wready,
    output logic           m1_bvalid,
    input  logic           m1_bready
);

    tcm_rd_if itcm_rd ();
    tcm_rd_if m1_itcm_rd ();
    tcm_rd_if dtcm_rd ();
    tcm_wr_if itcm_wr ();
    tcm_wr_if dtcm_wr ();

    data_port_router i_data_port_router (
        .clk        (clk),
        .rst_n      (rst_n),
        .m1_araddr  (m1_araddr),
        .m1_arvalid (m1_arvalid),
        .m1_arready (m1_arready),
        .m1_rdata   (m1_rdata),
        .m1_rvalid  (m1_rvalid),
        .m1_rready  (m1_rready),
        .m1_awaddr  (m1_awaddr),
        .m1_awvalid (m1_awvalid),
        .m1_awready (m1_awready),
        .m1_wdata   (m1_wdata),
        .m1_wstrb   (m1_wstrb),
        .m1_wvalid  (m1_wvalid),
        .m1_wready  (m1_wready),
        .m1_bvalid  (m1_bvalid),
        .m1_bready  (m1_bready),
        .itcm_rd    (m1_itcm_rd.master),
        .dtcm_rd    (dtcm_rd.master),
        .itcm_wr    (itcm_wr.master),
        .dtcm_wr    (dtcm_wr.master)
    );

    itcm_read_arbiter i_itcm_read_arbiter (
        .clk        (clk),
        .rst_n      (rst_n),
        .m0_araddr  (m0_araddr),
        .m0_arvalid (m0_arvalid),
        .m0_arready (m0_arready),
        .m0_rdata   (m0_rdata),
        .m0_rvalid  (m0_rvalid),
        .m0_rready  (m0_rready),
        .m1         (m1_itcm_rd.slave),
        .itcm       (itcm_rd.master)
    );

    tcm_ram i_itcm (
        .clk   (clk),
        .rst_n (rst_n),
        .rd    (itcm_rd.slave),
        .wr    (itcm_wr.slave)
    );

    tcm_ram i_dtcm (
        .clk   (clk),
        .rst_n (rst_n),
        .rd    (dtcm_rd.slave),
        .wr    (dtcm_wr.slave)
    );

endmodule

//--- bench/tb_tcm_subsystem.sv
/*
 * Self-checking testbench for the TCM subsystem. A stimulus table is
 * built against a word model of both banks, then applied in order.
 */
`timescale 1ns/10ps

module tb_tcm_subsystem;

    typedef enum logic [2:0] {
        OP_WRITE,   // M1 write
        OP_READ,    // M1 read
        OP_FETCH,   // M0 fetch
        OP_PAIR,    // M0 fetch and M1 read in the same cycle
        OP_HOLD,    // M0 fetch issued while m0_rready stays low
        OP_DRAIN    // collect one held M0 word
    } op_e;

    typedef struct packed {
        op_e            op;
        tcm_pkg::addr_t addr;
        tcm_pkg::data_t wdata;
        tcm_pkg::strb_t strb;
        tcm_pkg::data_t expected;
    } entry_t;

    localparam int TIMEOUT = 100;

    logic           clk;
    logic           rst_n;
    tcm_pkg::addr_t m0_araddr;
    logic           m0_arvalid;
    logic           m0_arready;
    tcm_pkg::data_t m0_rdata;
    logic           m0_rvalid;
    logic           m0_rready;
    tcm_pkg::addr_t m1_araddr;
    logic           m1_arvalid;
    logic           m1_arready;
    tcm_pkg::data_t m1_rdata;
    logic           m1_rvalid;
    logic           m1_rready;
    tcm_pkg::addr_t m1_awaddr;
    logic           m1_awvalid;
    logic           m1_awready;
    tcm_pkg::data_t m1_wdata;
    tcm_pkg::strb_t m1_wstrb;
    logic           m1_wvalid;
    logic           m1_wready;
    logic           m1_bvalid;
    logic           m1_bready;

    entry_t         stim_q [$];
    // bank 0 is the ITCM, bank 1 the DTCM
    tcm_pkg::data_t ref_mem [2][tcm_pkg::TCM_WORDS];
    logic [31:0]    rng_state;
    int             value_errors;
    int             timeouts;

    tcm_subsystem i_tcm_subsystem (
        .clk        (clk),
        .rst_n      (rst_n),
        .m0_araddr  (m0_araddr),
        .m0_arvalid (m0_arvalid),
        .m0_arready (m0_arready),
        .m0_rdata   (m0_rdata),
        .m0_rvalid  (m0_rvalid),
        .m0_rready  (m0_rready),
        .m1_araddr  (m1_araddr),
        .m1_arvalid (m1_arvalid),
        .m1_arready (m1_arready),
        .m1_rdata   (m1_rdata),
        .m1_rvalid  (m1_rvalid),
        .m1_rready  (m1_rready),
        .m1_awaddr  (m1_awaddr),
        .m1_awvalid (m1_awvalid),
        .m1_awready (m1_awready),
        .m1_wdata   (m1_wdata),
        .m1_wstrb   (m1_wstrb),
        .m1_wvalid  (m1_wvalid),
        .m1_wready  (m1_wready),
        .m1_bvalid  (m1_bvalid),
        .m1_bready  (m1_bready)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic logic random_bit();
        logic [31:0] r;
        r = next_rand();
        return r[16];
    endfunction

    function automatic tcm_pkg::data_t merge_bytes(tcm_pkg::data_t old_word,
                                                   tcm_pkg::data_t new_word,
                                                   tcm_pkg::strb_t strb);
        tcm_pkg::data_t result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    // appends one entry; writes update the model, reads take their value from it
    task automatic add_entry(input op_e op, input tcm_pkg::addr_t addr, input tcm_pkg::strb_t strb);
        entry_t e;
        logic   bank;
        bank       = (addr >= tcm_pkg::DTCM_BASE);
        e.op       = op;
        e.addr     = addr;
        e.strb     = strb;
        e.wdata    = '0;
        e.expected = ref_mem[bank][addr[9:2]];
        if (op == OP_WRITE) begin
            e.wdata = next_rand();
            ref_mem[bank][addr[9:2]] = merge_bytes(ref_mem[bank][addr[9:2]], e.wdata, strb);
            e.expected = ref_mem[bank][addr[9:2]];
        end
        stim_q.push_back(e);
    endtask

    task automatic expect_equal(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic require_done(input logic done, input string what);
        assert (done) else begin
            $display("timeout: %s did not arrive within %0d cycles", what, TIMEOUT);
            timeouts++;
        end
    endtask

    // every bus task starts and ends 2 ns after a rising edge
    task automatic m1_write(input tcm_pkg::addr_t addr, input tcm_pkg::data_t data,
                            input tcm_pkg::strb_t strb);
        int cycles;
        cycles     = 0;
        m1_awaddr  = addr;
        m1_wdata   = data;
        m1_wstrb   = strb;
        m1_awvalid = 1'b1;
        m1_wvalid  = 1'b1;
        @(negedge clk);
        while (!(m1_awready && m1_wready) && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        require_done(m1_awready && m1_wready, "m1_awready and m1_wready");
        @(posedge clk);
        #2;
        m1_awvalid = 1'b0;
        m1_wvalid  = 1'b0;
        m1_bready  = random_bit();
        cycles     = 0;
        @(negedge clk);
        // nothing else pending, so the response follows in one cycle
        expect_equal("m1_bvalid", 32'(m1_bvalid), 32'h1);
        while (!(m1_bvalid && m1_bready) && cycles < TIMEOUT) begin
            @(posedge clk);
            #2;
            m1_bready = random_bit();
            @(negedge clk);
            cycles++;
        end
        require_done(m1_bvalid && m1_bready, "m1_bvalid");
        @(posedge clk);
        #2;
        m1_bready = 1'b0;
    endtask

    task automatic m1_read(input tcm_pkg::addr_t addr, input tcm_pkg::data_t exp);
        int cycles;
        cycles     = 0;
        m1_araddr  = addr;
        m1_arvalid = 1'b1;
        @(negedge clk);
        while (!m1_arready && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        require_done(m1_arready, "m1_arready");
        @(posedge clk);
        #2;
        m1_arvalid = 1'b0;
        m1_rready  = random_bit();
        cycles     = 0;
        @(negedge clk);
        expect_equal("m1_rvalid", 32'(m1_rvalid), 32'h1);
        while (!(m1_rvalid && m1_rready) && cycles < TIMEOUT) begin
            @(posedge clk);
            #2;
            m1_rready = random_bit();
            @(negedge clk);
            cycles++;
        end
        require_done(m1_rvalid && m1_rready, "m1_rvalid");
        if (m1_rvalid && m1_rready) begin
            expect_equal("m1_rdata", m1_rdata, exp);
        end
        @(posedge clk);
        #2;
        m1_rready = 1'b0;
    endtask

    task automatic fetch_issue(input tcm_pkg::addr_t addr);
        int cycles;
        cycles     = 0;
        m0_araddr  = addr;
        m0_arvalid = 1'b1;
        @(negedge clk);
        while (!m0_arready && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        require_done(m0_arready, "m0_arready");
        @(posedge clk);
        #2;
        m0_arvalid = 1'b0;
    endtask

    task automatic fetch_collect(input tcm_pkg::data_t exp);
        int cycles;
        cycles    = 0;
        m0_rready = random_bit();
        @(negedge clk);
        while (!(m0_rvalid && m0_rready) && cycles < TIMEOUT) begin
            @(posedge clk);
            #2;
            m0_rready = random_bit();
            @(negedge clk);
            cycles++;
        end
        require_done(m0_rvalid && m0_rready, "m0_rvalid");
        if (m0_rvalid && m0_rready) begin
            expect_equal("m0_rdata", m0_rdata, exp);
        end
        @(posedge clk);
        #2;
        m0_rready = 1'b0;
    endtask

    initial begin
        entry_t e;
        clk          = 1'b0;
        rst_n        = 1'b0;
        m0_araddr    = '0;
        m0_arvalid   = 1'b0;
        m0_rready    = 1'b0;
        m1_araddr    = '0;
        m1_arvalid   = 1'b0;
        m1_rready    = 1'b0;
        m1_awaddr    = '0;
        m1_awvalid   = 1'b0;
        m1_wdata     = '0;
        m1_wstrb     = '0;
        m1_wvalid    = 1'b0;
        m1_bready    = 1'b0;
        value_errors = 0;
        timeouts     = 0;
        rng_state    = 32'd57;

        // DTCM write and read-back
        for (int i = 0; i < 4; i++) begin
            add_entry(OP_WRITE, tcm_pkg::DTCM_BASE + 32'(4 * i), 4'hf);
        end
        for (int i = 0; i < 4; i++) begin
            add_entry(OP_READ, tcm_pkg::DTCM_BASE + 32'(4 * i), 4'h0);
        end
        // byte merges on one word
        add_entry(OP_WRITE, tcm_pkg::DTCM_BASE + 32'h40, 4'hf);
        add_entry(OP_WRITE, tcm_pkg::DTCM_BASE + 32'h40, 4'b0001);
        add_entry(OP_READ, tcm_pkg::DTCM_BASE + 32'h40, 4'h0);
        add_entry(OP_WRITE, tcm_pkg::DTCM_BASE + 32'h40, 4'b0110);
        add_entry(OP_WRITE, tcm_pkg::DTCM_BASE + 32'h40, 4'b1000);
        add_entry(OP_READ, tcm_pkg::DTCM_BASE + 32'h40, 4'h0);
        add_entry(OP_WRITE, tcm_pkg::DTCM_BASE + 32'h40, 4'b1010);
        add_entry(OP_READ, tcm_pkg::DTCM_BASE + 32'h40, 4'h0);
        // ITCM loaded by M1, fetched by M0
        for (int i = 0; i < 6; i++) begin
            add_entry(OP_WRITE, tcm_pkg::ITCM_BASE + 32'(4 * i), 4'hf);
        end
        add_entry(OP_WRITE, tcm_pkg::ITCM_BASE + 32'h3fc, 4'hf);
        for (int i = 0; i < 6; i++) begin
            add_entry(OP_FETCH, tcm_pkg::ITCM_BASE + 32'(4 * i), 4'h0);
        end
        add_entry(OP_FETCH, tcm_pkg::ITCM_BASE + 32'h3fc, 4'h0);
        // M0 stalled on three fetches while M1 reads both banks
        for (int i = 0; i < 3; i++) begin
            add_entry(OP_HOLD, tcm_pkg::ITCM_BASE + 32'(4 * i), 4'h0);
        end
        add_entry(OP_READ, tcm_pkg::ITCM_BASE + 32'h10, 4'h0);
        add_entry(OP_READ, tcm_pkg::DTCM_BASE + 32'h40, 4'h0);
        for (int i = 0; i < 3; i++) begin
            add_entry(OP_DRAIN, tcm_pkg::ITCM_BASE + 32'(4 * i), 4'h0);
        end
        // both masters on the ITCM at once
        for (int i = 2; i < 6; i++) begin
            add_entry(OP_PAIR, tcm_pkg::ITCM_BASE + 32'(4 * i), 4'h0);
        end

        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(negedge clk);
        expect_equal("m0_rvalid", 32'(m0_rvalid), 32'h0);
        expect_equal("m1_rvalid", 32'(m1_rvalid), 32'h0);
        expect_equal("m1_bvalid", 32'(m1_bvalid), 32'h0);
        @(posedge clk);
        #2;

        foreach (stim_q[i]) begin
            e = stim_q[i];
            case (e.op)
                OP_WRITE: m1_write(e.addr, e.wdata, e.strb);
                OP_READ:  m1_read(e.addr, e.expected);
                OP_FETCH: begin
                    fetch_issue(e.addr);
                    fetch_collect(e.expected);
                end
                OP_HOLD:  fetch_issue(e.addr);
                OP_DRAIN: fetch_collect(e.expected);
                OP_PAIR: begin
                    fork
                        m1_read(e.addr, e.expected);
                        begin
                            fetch_issue(e.addr);
                            fetch_collect(e.expected);
                        end
                        begin
                            // fixed priority: M1 takes the first slot
                            @(negedge clk);
                            expect_equal("m1_arready", 32'(m1_arready), 32'h1);
                            expect_equal("m0_arready", 32'(m0_arready), 32'h0);
                        end
                    join
                end
                default: begin
                    $display("table entry %0d has an unknown operation", i);
                    value_errors++;
                end
            endcase
        end

        $display("errors: %0d value mismatches, %0d timeouts", value_errors, timeouts);
        if (value_errors == 0 && timeouts == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
hdl/tcm_pkg.sv
hdl/tcm_if.sv
hdl/tcm_ram.sv
hdl/fetch_resp_fifo.sv
hdl/itcm_read_arbiter.sv
hdl/data_port_router.sv
hdl/tcm_subsystem.sv
bench/tb_tcm_subsystem.sv

//--- Makefile
# Verilator build and run of the TCM subsystem testbench

TOP := tb_tcm_subsystem

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f verilog.f

run: compile
	./obj_dir/V$(TOP) | tee run.log
	@grep -q "TB PASSED" run.log

clean:
	rm -rf obj_dir run.log
